//--- logic/island_pkg.sv
// Shared bus widths, boot modes and address map, imported by every block of the island fabric
package island_pkg;

  // ------------------------------------------------------------------------
  // Bus widths
  // ------------------------------------------------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  typedef enum logic [1:0] {
    BootPreloaded = 2'd0,
    BootJtag      = 2'd1,
    BootFlash     = 2'd2
  } bootmode_e;

  // Crossbar shape, slaves in order bank 0, bank 1, peripherals
  localparam int unsigned NumMasters = 2;
  localparam int unsigned NumSlaves  = 3;

  typedef logic [1:0] slave_idx_t;

  // ------------------------------------------------------------------------
  // Address map, relative to the island base
  // ------------------------------------------------------------------------
  localparam addr_t PeriphOffset = 32'h0020_0000;

  // Slots inside the peripheral region
  localparam addr_t SocCtrlOffset   = 32'h0000_0000;
  localparam addr_t BootRomOffset   = 32'h0000_1000;
  localparam addr_t PeriphSlotBytes = 32'h0000_1000;

  // Reset entry point inside the boot ROM
  localparam addr_t BootEntryOffset = 32'h0000_0080;

  // Read data of the error responder
  localparam data_t ErrorWord = 32'hBADC_AB1E;

endpackage

//--- logic/sram_bank.sv
// Single-port SRAM bank with byte enables, grants every request and answers on the next cycle
`timescale 1ns/100ps

module sram_bank #(
  parameter int unsigned NumWords = 8192
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic              we_i,
  input  island_pkg::strb_t be_i,
  input  island_pkg::addr_t addr_i,
  input  island_pkg::data_t wdata_i,
  output logic              gnt_o,
  output island_pkg::data_t rdata_o,
  output logic              err_o
);
  import island_pkg::*;

  localparam int unsigned IdxWidth = $clog2(NumWords);

  data_t               mem_q [NumWords];
  logic [IdxWidth-1:0] idx;
  data_t               rdata_q;

  // Word index, bank select bits above are dropped
  assign idx   = addr_i[IdxWidth+1:2];
  assign gnt_o = req_i;
  assign err_o = 1'b0;

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (be_i[b]) begin
          mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- logic/boot_rom.sv
// Constant boot code table, read one cycle after the request and blind to writes
`timescale 1ns/100ps

module boot_rom #(
  parameter int unsigned RomWords = 64
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           req_i,
  input  logic [$clog2(island_pkg::PeriphSlotBytes)-3:0] word_addr_i,
  output island_pkg::data_t                              rdata_o
);
  import island_pkg::*;

  localparam int unsigned RomAw        = $clog2(RomWords);
  localparam data_t       InsnNop      = 32'h0000_0013;
  localparam data_t       InsnJumpSelf = 32'h0000_006f;

  typedef data_t [RomWords-1:0] rom_t;

  // NOP sled ending in a jump to itself
  function automatic rom_t init_rom();
    rom_t tbl;
    tbl               = {RomWords{InsnNop}};
    tbl[RomWords-1]   = InsnJumpSelf;
    return tbl;
  endfunction

  localparam rom_t RomTable = init_rom();

  data_t rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i) begin
      if (word_addr_i < RomWords) begin
        rdata_q <= RomTable[word_addr_i[RomAw-1:0]];
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- logic/soc_ctrl_regs.sv
// SoC control registers holding the boot address and fetch enable, with the JTAG boot override
`timescale 1ns/100ps

module soc_ctrl_regs #(
  parameter island_pkg::addr_t BootAddrDefault = 32'h0000_0000
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  island_pkg::bootmode_e                          bootmode_i,
  input  logic                                           req_i,
  input  logic                                           we_i,
  input  island_pkg::strb_t                              be_i,
  input  logic [$clog2(island_pkg::PeriphSlotBytes)-3:0] word_addr_i,
  input  island_pkg::data_t                              wdata_i,
  output island_pkg::data_t                              rdata_o,
  output logic                                           err_o,
  output logic                                           fetch_enable_o,
  output island_pkg::addr_t                              boot_addr_o
);
  import island_pkg::*;

  localparam int unsigned WordAw = $clog2(PeriphSlotBytes) - 2;

  // Word offsets 0x0 and 0x4
  localparam logic [WordAw-1:0] BootAddrWord = WordAw'(0);
  localparam logic [WordAw-1:0] FetchEnWord  = WordAw'(1);

  addr_t boot_addr_q;
  logic  fetch_en_q;
  data_t rdata_q;
  logic  err_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_addr_q <= BootAddrDefault;
      fetch_en_q  <= 1'b0;
    end else if (req_i && we_i) begin
      if (word_addr_i == BootAddrWord) begin
        for (int b = 0; b < $bits(strb_t); b++) begin
          if (be_i[b]) begin
            boot_addr_q[8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end else if (word_addr_i == FetchEnWord && be_i[0]) begin
        fetch_en_q <= wdata_i[0];
      end
    end
  end

  // Read response, unused offsets flag an error
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
      err_q   <= 1'b0;
    end else if (req_i) begin
      unique case (word_addr_i)
        BootAddrWord: begin
          rdata_q <= boot_addr_q;
          err_q   <= 1'b0;
        end
        FetchEnWord: begin
          rdata_q <= data_t'(fetch_en_q);
          err_q   <= 1'b0;
        end
        default: begin
          rdata_q <= '0;
          err_q   <= 1'b1;
        end
      endcase
    end
  end

  assign rdata_o        = rdata_q;
  assign err_o          = err_q;
  assign boot_addr_o    = boot_addr_q;
  assign fetch_enable_o = fetch_en_q || (bootmode_i == BootJtag);

endmodule

//--- logic/periph_demux.sv
// Peripheral demultiplexer, decodes slots to control registers and boot ROM, errors otherwise
`timescale 1ns/100ps

module periph_demux #(
  parameter island_pkg::addr_t BaseAddr  = 32'h0000_0000,
  parameter island_pkg::addr_t AddrRange = 32'h0080_0000
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  island_pkg::bootmode_e bootmode_i,
  input  logic                  req_i,
  input  logic                  we_i,
  input  island_pkg::strb_t     be_i,
  input  island_pkg::addr_t     addr_i,
  input  island_pkg::data_t     wdata_i,
  output logic                  gnt_o,
  output island_pkg::data_t     rdata_o,
  output logic                  err_o,
  output logic                  fetch_enable_o,
  output island_pkg::addr_t     boot_addr_o
);
  import island_pkg::*;

  localparam addr_t       PeriphBase      = BaseAddr + PeriphOffset;
  localparam addr_t       IslandEnd       = BaseAddr + AddrRange;
  localparam addr_t       BootAddrDefault = PeriphBase + BootRomOffset + BootEntryOffset;
  localparam int unsigned SlotAw          = $clog2(PeriphSlotBytes);

  localparam logic [1:0] TgtError = 2'd0;
  localparam logic [1:0] TgtCtrl  = 2'd1;
  localparam logic [1:0] TgtRom   = 2'd2;

  addr_t      periph_off;
  addr_t      slot_base;
  logic [1:0] tgt;
  logic [1:0] tgt_q;
  data_t      ctrl_rdata;
  logic       ctrl_err;
  data_t      rom_rdata;

  // ------------------------------------------------------------------------
  // Slot decode
  // ------------------------------------------------------------------------
  assign periph_off = addr_i - PeriphBase;
  assign slot_base  = periph_off & ~(PeriphSlotBytes - 1);

  always_comb begin
    tgt = TgtError;
    if (addr_i >= PeriphBase && addr_i < IslandEnd) begin
      if (slot_base == SocCtrlOffset) begin
        tgt = TgtCtrl;
      end else if (slot_base == BootRomOffset) begin
        tgt = TgtRom;
      end
    end
  end

  // Every target answers in one cycle, so no back-pressure here
  assign gnt_o = 1'b1;

  soc_ctrl_regs #(
    .BootAddrDefault ( BootAddrDefault )
  ) i_soc_ctrl (
    .clk_i,
    .rst_ni,
    .bootmode_i,
    .req_i       ( req_i && (tgt == TgtCtrl) ),
    .we_i,
    .be_i,
    .word_addr_i ( periph_off[SlotAw-1:2]    ),
    .wdata_i,
    .rdata_o     ( ctrl_rdata                ),
    .err_o       ( ctrl_err                  ),
    .fetch_enable_o,
    .boot_addr_o
  );

  boot_rom i_boot_rom (
    .clk_i,
    .rst_ni,
    .req_i       ( req_i && (tgt == TgtRom) ),
    .word_addr_i ( periph_off[SlotAw-1:2]   ),
    .rdata_o     ( rom_rdata                )
  );

  // ------------------------------------------------------------------------
  // Response return and error responder
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tgt_q <= TgtError;
    end else if (req_i) begin
      tgt_q <= tgt;
    end
  end

  always_comb begin
    unique case (tgt_q)
      TgtCtrl: begin
        // Unused register offsets answer like the error responder
        rdata_o = ctrl_err ? ErrorWord : ctrl_rdata;
        err_o   = ctrl_err;
      end
      TgtRom: begin
        rdata_o = rom_rdata;
        err_o   = 1'b0;
      end
      default: begin
        rdata_o = ErrorWord;
        err_o   = 1'b1;
      end
    endcase
  end

endmodule

//--- logic/island_xbar.sv
// Two-master crossbar with address decode, per-slave round robin and one-cycle response return
`timescale 1ns/100ps

module island_xbar #(
  parameter island_pkg::addr_t BaseAddr     = 32'h0000_0000,
  parameter island_pkg::addr_t BankNumBytes = 32'h0000_8000
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,

  input  logic              [island_pkg::NumMasters-1:0] m_req_i,
  input  logic              [island_pkg::NumMasters-1:0] m_we_i,
  input  island_pkg::strb_t [island_pkg::NumMasters-1:0] m_be_i,
  input  island_pkg::addr_t [island_pkg::NumMasters-1:0] m_addr_i,
  input  island_pkg::data_t [island_pkg::NumMasters-1:0] m_wdata_i,
  output logic              [island_pkg::NumMasters-1:0] m_gnt_o,
  output logic              [island_pkg::NumMasters-1:0] m_rvalid_o,
  output island_pkg::data_t [island_pkg::NumMasters-1:0] m_rdata_o,
  output logic              [island_pkg::NumMasters-1:0] m_err_o,

  output logic              [island_pkg::NumSlaves-1:0]  slv_req_o,
  output logic              [island_pkg::NumSlaves-1:0]  slv_we_o,
  output island_pkg::strb_t [island_pkg::NumSlaves-1:0]  slv_be_o,
  output island_pkg::addr_t [island_pkg::NumSlaves-1:0]  slv_addr_o,
  output island_pkg::data_t [island_pkg::NumSlaves-1:0]  slv_wdata_o,
  input  logic              [island_pkg::NumSlaves-1:0]  slv_gnt_i,
  input  island_pkg::data_t [island_pkg::NumSlaves-1:0]  slv_rdata_i,
  input  logic              [island_pkg::NumSlaves-1:0]  slv_err_i
);
  import island_pkg::*;

  localparam slave_idx_t SlvBank0  = 2'd0;
  localparam slave_idx_t SlvBank1  = 2'd1;
  localparam slave_idx_t SlvPeriph = 2'd2;

  slave_idx_t [NumMasters-1:0]                 m_idx;
  slave_idx_t [NumMasters-1:0]                 m_idx_q;
  logic       [NumMasters-1:0]                 m_rvalid_q;
  logic       [NumSlaves-1:0][NumMasters-1:0] slv_hit;
  logic       [NumSlaves-1:0][NumMasters-1:0] slv_gnt_mst;
  logic       [NumSlaves-1:0]                 slv_sel;
  logic       [NumSlaves-1:0]                 rr_q;

  // ------------------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------------------
  for (genvar m = 0; m < NumMasters; m++) begin : gen_decode
    addr_t offset;

    // Addresses below the base wrap around and fall to the peripheral port
    assign offset   = m_addr_i[m] - BaseAddr;
    assign m_idx[m] = (offset < BankNumBytes)     ? SlvBank0 :
                      (offset < 2 * BankNumBytes) ? SlvBank1 : SlvPeriph;
  end

  // ------------------------------------------------------------------------
  // Per-slave arbitration
  // ------------------------------------------------------------------------
  for (genvar s = 0; s < NumSlaves; s++) begin : gen_arb
    for (genvar m = 0; m < NumMasters; m++) begin : gen_hit
      assign slv_hit[s][m] = m_req_i[m] && (m_idx[m] == slave_idx_t'(s));
    end

    // Pointer only decides a conflict
    assign slv_sel[s] = (&slv_hit[s]) ? rr_q[s] : slv_hit[s][1];

    assign slv_req_o[s]   = |slv_hit[s];
    assign slv_we_o[s]    = m_we_i[slv_sel[s]];
    assign slv_be_o[s]    = m_be_i[slv_sel[s]];
    assign slv_addr_o[s]  = m_addr_i[slv_sel[s]];
    assign slv_wdata_o[s] = m_wdata_i[slv_sel[s]];

    assign slv_gnt_mst[s] = slv_gnt_i[s] ? (slv_hit[s] & (NumMasters'(1) << slv_sel[s])) : '0;
  end

  always_comb begin
    m_gnt_o = '0;
    for (int s = 0; s < NumSlaves; s++) begin
      m_gnt_o |= slv_gnt_mst[s];
    end
  end

  // Hand priority to the loser after a contested grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else begin
      for (int s = 0; s < NumSlaves; s++) begin
        if ((&slv_hit[s]) && slv_gnt_i[s]) begin
          rr_q[s] <= ~rr_q[s];
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // Response return
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_rvalid_q <= '0;
      m_idx_q    <= '0;
    end else begin
      m_rvalid_q <= m_gnt_o;
      for (int m = 0; m < NumMasters; m++) begin
        if (m_gnt_o[m]) begin
          m_idx_q[m] <= m_idx[m];
        end
      end
    end
  end

  assign m_rvalid_o = m_rvalid_q;

  for (genvar m = 0; m < NumMasters; m++) begin : gen_resp
    assign m_rdata_o[m] = slv_rdata_i[m_idx_q[m]];
    assign m_err_o[m]   = slv_err_i[m_idx_q[m]];
  end

endmodule

//--- logic/island_top.sv
// Island top level, joins two bus masters to the SRAM banks and the peripheral subsystem
`timescale 1ns/100ps

module island_top #(
  parameter island_pkg::addr_t BaseAddr     = 32'h0000_0000,
  parameter island_pkg::addr_t AddrRange    = 32'h0080_0000,
  parameter island_pkg::addr_t BankNumBytes = 32'h0000_8000
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  island_pkg::bootmode_e                          bootmode_i,

  input  logic              [island_pkg::NumMasters-1:0] m_req_i,
  input  logic              [island_pkg::NumMasters-1:0] m_we_i,
  input  island_pkg::strb_t [island_pkg::NumMasters-1:0] m_be_i,
  input  island_pkg::addr_t [island_pkg::NumMasters-1:0] m_addr_i,
  input  island_pkg::data_t [island_pkg::NumMasters-1:0] m_wdata_i,
  output logic              [island_pkg::NumMasters-1:0] m_gnt_o,
  output logic              [island_pkg::NumMasters-1:0] m_rvalid_o,
  output island_pkg::data_t [island_pkg::NumMasters-1:0] m_rdata_o,
  output logic              [island_pkg::NumMasters-1:0] m_err_o,

  output logic                                           fetch_enable_o,
  output island_pkg::addr_t                              boot_addr_o
);
  import island_pkg::*;

  localparam int unsigned BankNumWords = BankNumBytes / 4;

  // ------------------------------------------------------------------------
  // Slave side of the crossbar
  // ------------------------------------------------------------------------
  logic  [NumSlaves-1:0] slv_req;
  logic  [NumSlaves-1:0] slv_we;
  strb_t [NumSlaves-1:0] slv_be;
  addr_t [NumSlaves-1:0] slv_addr;
  data_t [NumSlaves-1:0] slv_wdata;
  logic  [NumSlaves-1:0] slv_gnt;
  data_t [NumSlaves-1:0] slv_rdata;
  logic  [NumSlaves-1:0] slv_err;

  island_xbar #(
    .BaseAddr     ( BaseAddr     ),
    .BankNumBytes ( BankNumBytes )
  ) i_xbar (
    .clk_i,
    .rst_ni,
    .m_req_i,
    .m_we_i,
    .m_be_i,
    .m_addr_i,
    .m_wdata_i,
    .m_gnt_o,
    .m_rvalid_o,
    .m_rdata_o,
    .m_err_o,
    .slv_req_o   ( slv_req   ),
    .slv_we_o    ( slv_we    ),
    .slv_be_o    ( slv_be    ),
    .slv_addr_o  ( slv_addr  ),
    .slv_wdata_o ( slv_wdata ),
    .slv_gnt_i   ( slv_gnt   ),
    .slv_rdata_i ( slv_rdata ),
    .slv_err_i   ( slv_err   )
  );

  // ------------------------------------------------------------------------
  // Memories
  // ------------------------------------------------------------------------
  sram_bank #(
    .NumWords ( BankNumWords )
  ) i_bank0 (
    .clk_i,
    .rst_ni,
    .req_i   ( slv_req[0]   ),
    .we_i    ( slv_we[0]    ),
    .be_i    ( slv_be[0]    ),
    .addr_i  ( slv_addr[0]  ),
    .wdata_i ( slv_wdata[0] ),
    .gnt_o   ( slv_gnt[0]   ),
    .rdata_o ( slv_rdata[0] ),
    .err_o   ( slv_err[0]   )
  );

  sram_bank #(
    .NumWords ( BankNumWords )
  ) i_bank1 (
    .clk_i,
    .rst_ni,
    .req_i   ( slv_req[1]   ),
    .we_i    ( slv_we[1]    ),
    .be_i    ( slv_be[1]    ),
    .addr_i  ( slv_addr[1]  ),
    .wdata_i ( slv_wdata[1] ),
    .gnt_o   ( slv_gnt[1]   ),
    .rdata_o ( slv_rdata[1] ),
    .err_o   ( slv_err[1]   )
  );

  // Peripherals, also the default route for unmapped addresses
  periph_demux #(
    .BaseAddr  ( BaseAddr  ),
    .AddrRange ( AddrRange )
  ) i_periph (
    .clk_i,
    .rst_ni,
    .bootmode_i,
    .req_i   ( slv_req[2]   ),
    .we_i    ( slv_we[2]    ),
    .be_i    ( slv_be[2]    ),
    .addr_i  ( slv_addr[2]  ),
    .wdata_i ( slv_wdata[2] ),
    .gnt_o   ( slv_gnt[2]   ),
    .rdata_o ( slv_rdata[2] ),
    .err_o   ( slv_err[2]   ),
    .fetch_enable_o,
    .boot_addr_o
  );

endmodule

//--- verification/tb_island_top.sv
// Directed testbench for the island fabric, run as the simulation top with build.f
`timescale 1ns/100ps

module tb_island_top;
  import island_pkg::*;

  // Address map seen from the masters, default top parameters
  localparam addr_t       BaseAddr      = 32'h0000_0000;
  localparam addr_t       BankBytes     = 32'h0000_8000;
  localparam addr_t       Bank0Base     = BaseAddr;
  localparam addr_t       Bank1Base     = BaseAddr + BankBytes;
  localparam addr_t       PeriphBase    = BaseAddr + PeriphOffset;
  localparam addr_t       CtrlBase      = PeriphBase + SocCtrlOffset;
  localparam addr_t       RomBase       = PeriphBase + BootRomOffset;
  localparam addr_t       BootAddrReset = RomBase + BootEntryOffset;
  localparam int unsigned RomWords      = 64;
  localparam data_t       InsnNop       = 32'h0000_0013;
  localparam data_t       InsnJumpSelf  = 32'h0000_006f;

  // Directed tests take a few hundred cycles, the limit leaves wide margin
  localparam int TimeoutCycles = 3000;

  logic                  clk_i;
  logic                  rst_ni;
  bootmode_e             bootmode;
  logic [NumMasters-1:0] m_req;
  logic [NumMasters-1:0] m_we;
  strb_t [NumMasters-1:0] m_be;
  addr_t [NumMasters-1:0] m_addr;
  data_t [NumMasters-1:0] m_wdata;
  logic [NumMasters-1:0] m_gnt_o;
  logic [NumMasters-1:0] m_rvalid_o;
  data_t [NumMasters-1:0] m_rdata_o;
  logic [NumMasters-1:0] m_err_o;
  logic                  fetch_enable_o;
  addr_t                 boot_addr_o;

  int    seed = 32'h52ec;
  int    cycle_count = 0;
  int    last_gnt_cycle [NumMasters];
  data_t sram_model [addr_t];

  island_top dut_i (
    .clk_i,
    .rst_ni,
    .bootmode_i ( bootmode   ),
    .m_req_i    ( m_req      ),
    .m_we_i     ( m_we       ),
    .m_be_i     ( m_be       ),
    .m_addr_i   ( m_addr     ),
    .m_wdata_i  ( m_wdata    ),
    .m_gnt_o,
    .m_rvalid_o,
    .m_rdata_o,
    .m_err_o,
    .fetch_enable_o,
    .boot_addr_o
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TimeoutCycles) begin
      $display("Run stopped after %0d cycles without finishing the tests", TimeoutCycles);
      $display("Simulation FAILED");
      $fatal(1, "Timeout");
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR: time %0t, %s is %h, expected %h", $time, name, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t be);
    data_t res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  // NOP table that ends in a jump to itself
  function automatic data_t rom_word(int unsigned word);
    if (word >= RomWords) begin
      return '0;
    end
    if (word == RomWords - 1) begin
      return InsnJumpSelf;
    end
    return InsnNop;
  endfunction

  // One request, held until granted; the response must follow one cycle later
  task automatic bus_access(input int m, input logic we, input strb_t be, input addr_t addr,
                            input data_t wdata, output data_t rdata, output logic err);
    @(posedge clk_i);
    #2;
    m_req[m]   = 1'b1;
    m_we[m]    = we;
    m_be[m]    = be;
    m_addr[m]  = addr;
    m_wdata[m] = wdata;
    do begin
      @(negedge clk_i);
      check_value($sformatf("m_rvalid_o[%0d]", m), m_rvalid_o[m], 0);
    end while (!m_gnt_o[m]);
    last_gnt_cycle[m] = cycle_count;
    @(posedge clk_i);
    #2;
    m_req[m] = 1'b0;
    @(negedge clk_i);
    check_value($sformatf("m_rvalid_o[%0d]", m), m_rvalid_o[m], 1);
    rdata = m_rdata_o[m];
    err   = m_err_o[m];
  endtask

  task automatic bus_write(input int m, input addr_t addr, input data_t wdata, input strb_t be,
                           output logic err);
    data_t unused;
    bus_access(m, 1'b1, be, addr, wdata, unused, err);
  endtask

  task automatic bus_read(input int m, input addr_t addr, output data_t rdata,
                          output logic err);
    bus_access(m, 1'b0, 4'hF, addr, '0, rdata, err);
  endtask

  task automatic write_sram(input int m, input addr_t addr, input data_t wdata, input strb_t be);
    logic err;
    bus_write(m, addr, wdata, be, err);
    check_value($sformatf("m_err_o[%0d]", m), err, 0);
    sram_model[addr] = merge_bytes(sram_model.exists(addr) ? sram_model[addr] : '0, wdata, be);
  endtask

  task automatic expect_sram(input int m, input addr_t addr);
    data_t rdata;
    logic  err;
    bus_read(m, addr, rdata, err);
    check_value($sformatf("m_rdata_o[%0d]", m), rdata, sram_model[addr]);
    check_value($sformatf("m_err_o[%0d]", m), err, 0);
  endtask

  task automatic expect_read(input int m, input addr_t addr, input data_t exp_data,
                             input logic exp_err);
    data_t rdata;
    logic  err;
    bus_read(m, addr, rdata, err);
    check_value($sformatf("m_rdata_o[%0d]", m), rdata, exp_data);
    check_value($sformatf("m_err_o[%0d]", m), err, exp_err);
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  task automatic after_reset();
    @(negedge clk_i);
    check_value("m_rvalid_o", m_rvalid_o, 0);
    check_value("boot_addr_o", boot_addr_o, BootAddrReset);
    check_value("fetch_enable_o", fetch_enable_o, 0);
  endtask

  task automatic sram_traffic();
    strb_t partial_be [4];
    addr_t addr;
    partial_be = '{4'b0001, 4'b0110, 4'b1000, 4'b1011};
    for (int m = 0; m < NumMasters; m++) begin
      for (int b = 0; b < 2; b++) begin
        for (int i = 0; i < 4; i++) begin
          addr = (b == 0 ? Bank0Base : Bank1Base) + (addr_t'($random(seed)) & 32'h7FFC);
          write_sram(m, addr, $random(seed), 4'hF);
          expect_sram(m, addr);
          expect_sram(1 - m, addr);
          write_sram(m, addr, $random(seed), partial_be[i]);
          expect_sram(m, addr);
          expect_sram(1 - m, addr);
        end
      end
    end
  endtask

  task automatic bank_contention();
    addr_t a_addr;
    addr_t b_addr;
    data_t rd0;
    data_t rd1;
    logic  e0;
    logic  e1;
    int    first;
    for (int b = 0; b < 2; b++) begin
      a_addr = (b == 0 ? Bank0Base : Bank1Base) + 32'h100;
      b_addr = a_addr + 32'h4;
      write_sram(0, a_addr, $random(seed), 4'hF);
      write_sram(1, b_addr, $random(seed), 4'hF);

      // First conflict, either master may win
      fork
        bus_read(0, a_addr, rd0, e0);
        bus_read(1, b_addr, rd1, e1);
      join
      check_value("m_rdata_o[0]", rd0, sram_model[a_addr]);
      check_value("m_rdata_o[1]", rd1, sram_model[b_addr]);
      check_value("m_err_o", {e1, e0}, 0);
      first = (last_gnt_cycle[0] < last_gnt_cycle[1]) ? 0 : 1;
      check_value("m_gnt_o spacing", last_gnt_cycle[1-first] - last_gnt_cycle[first], 1);

      // Second conflict, the other master wins
      fork
        bus_read(0, b_addr, rd0, e0);
        bus_read(1, a_addr, rd1, e1);
      join
      check_value("m_rdata_o[0]", rd0, sram_model[b_addr]);
      check_value("m_rdata_o[1]", rd1, sram_model[a_addr]);
      check_value("m_err_o", {e1, e0}, 0);
      check_value("m_gnt_o spacing", last_gnt_cycle[first] - last_gnt_cycle[1-first], 1);
    end
  endtask

  task automatic control_registers();
    addr_t exp_boot;
    logic  err;
    exp_boot = BootAddrReset;
    bus_write(0, CtrlBase, 32'hDEAD_BEEF, 4'b0011, err);
    check_value("m_err_o[0]", err, 0);
    exp_boot = merge_bytes(exp_boot, 32'hDEAD_BEEF, 4'b0011);
    check_value("boot_addr_o", boot_addr_o, exp_boot);
    expect_read(1, CtrlBase, exp_boot, 1'b0);

    bus_write(1, CtrlBase, 32'h1C00_0000, 4'b1100, err);
    check_value("m_err_o[1]", err, 0);
    exp_boot = merge_bytes(exp_boot, 32'h1C00_0000, 4'b1100);
    check_value("boot_addr_o", boot_addr_o, exp_boot);
    expect_read(0, CtrlBase, exp_boot, 1'b0);

    bus_write(0, CtrlBase + 32'h4, 32'h1, 4'h1, err);
    check_value("m_err_o[0]", err, 0);
    check_value("fetch_enable_o", fetch_enable_o, 1);
    expect_read(1, CtrlBase + 32'h4, 32'h1, 1'b0);
    bus_write(0, CtrlBase + 32'h4, 32'h0, 4'h1, err);
    check_value("m_err_o[0]", err, 0);
    check_value("fetch_enable_o", fetch_enable_o, 0);

    // JTAG boot forces fetch on while the register bit stays clear
    @(posedge clk_i);
    #2;
    bootmode = BootJtag;
    @(negedge clk_i);
    check_value("fetch_enable_o", fetch_enable_o, 1);
    expect_read(0, CtrlBase + 32'h4, 32'h0, 1'b0);
    @(posedge clk_i);
    #2;
    bootmode = BootPreloaded;
    @(negedge clk_i);
    check_value("fetch_enable_o", fetch_enable_o, 0);
  endtask

  task automatic boot_rom_reads();
    logic err;
    expect_read(0, BootAddrReset, rom_word(BootEntryOffset / 4), 1'b0);
    expect_read(1, RomBase + (RomWords - 1) * 4, rom_word(RomWords - 1), 1'b0);
    expect_read(0, RomBase + RomWords * 4, rom_word(RomWords), 1'b0);
    bus_write(1, BootAddrReset, 32'hFFFF_FFFF, 4'hF, err);
    check_value("m_err_o[1]", err, 0);
    expect_read(0, BootAddrReset, rom_word(BootEntryOffset / 4), 1'b0);
  endtask

  task automatic error_responses();
    addr_t bad_addr [3];
    addr_t boot_before;
    logic  fetch_before;
    logic  err;
    bad_addr = '{PeriphBase + 2 * PeriphSlotBytes, Bank1Base + BankBytes, CtrlBase + 32'h8};
    foreach (bad_addr[i]) begin
      expect_read(i % 2, bad_addr[i], ErrorWord, 1'b1);
      boot_before  = boot_addr_o;
      fetch_before = fetch_enable_o;
      bus_write(i % 2, bad_addr[i], $random(seed), 4'hF, err);
      check_value("m_err_o", err, 1);
      check_value("boot_addr_o", boot_addr_o, boot_before);
      check_value("fetch_enable_o", fetch_enable_o, fetch_before);
      expect_read(1 - i % 2, bad_addr[i], ErrorWord, 1'b1);
    end
  endtask

  // Every word written so far must still hold its model value
  task automatic sram_sweep();
    foreach (sram_model[a]) begin
      expect_sram(0, a);
    end
  endtask

  initial begin
    rst_ni   = 1'b0;
    bootmode = BootPreloaded;
    m_req    = '0;
    m_we     = '0;
    m_be     = '0;
    m_addr   = '0;
    m_wdata  = '0;
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    after_reset();
    sram_traffic();
    bank_contention();
    control_registers();
    boot_rom_reads();
    error_responses();
    sram_sweep();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- build.f
logic/island_pkg.sv
logic/sram_bank.sv
logic/boot_rom.sv
logic/soc_ctrl_regs.sv
logic/periph_demux.sv
logic/island_xbar.sv
logic/island_top.sv
verification/tb_island_top.sv

//--- run_sim.sh
#!/bin/sh
# Compile the island fabric with Verilator and run the directed testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_island_top \
  -Mdir obj_dir -o tb_island_top
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/tb_island_top 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation binary exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "Simulation PASSED"; then
  exit 0
fi
exit 1
